//--- bench/ooo_execute_asserts.sv
// Concurrent checks on the execute stage top level
// Reference rules for ALU, branch, jump and multiply results,
// reset, flush/halt and busy timing
module ooo_execute_asserts import exec_pkg::*; #(
  parameter int WORD_W = XLEN
) (
  input logic              CLK, nRST, halt, flush, pc_en,
  input logic [WORD_W-1:0] port_a, port_b,
  input word_t             pc, imm, jump_base, jump_offset,
  input alu_op_t           aluop,
  input branch_type_t      branch_type,
  input logic              w_src, dec_wen_au, dec_branch_instr, prediction, dec_jump_instr,
  input logic              mult_start, mult_signed, mult_high, dec_wen_mu,
  input logic              busy, mispredict, wen_au, wen_mu, branch_instr, branch_taken_q,
  input logic              jump_instr, prediction_q,
  input word_t             brj_addr, wdata_au, wdata_mu, br_resolved_addr, jump_addr_q, pc_q,
  input reg_idx_t          reg_rd, reg_rd_q
);

  timeunit 1ns;
  timeprecision 100ps;

  int    error_count = 0;
  int    busy_len;
  logic  clear;
  logic  load;
  logic  taken_exp;
  word_t alu_exp;
  word_t resolved_exp;
  word_t jump_sum;
  word_t jump_exp;
  word_t mult_exp;

  function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b,
                                    input word_t pc_v, input logic link);
    if (link) return pc_v + 32'd4;
    case (op)
      ADD:     return a + b;
      SUB:     return a + ~b + 32'd1;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      SRA:     return (a >> b[4:0]) | (a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'd0);
      SLT:     return {31'd0, $signed(a) < $signed(b)};
      SLTU:    return {31'd0, a < b};
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic taken_ref(input branch_type_t t, input word_t a, input word_t b);
    case (t)
      BEQ:     return a == b;
      BNE:     return a != b;
      BLT:     return $signed(a) < $signed(b);
      BGE:     return $signed(a) >= $signed(b);
      BLTU:    return a < b;
      BGEU:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Sign or zero extend both operands, then keep one half of the product
  function automatic word_t mult_ref(input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] b,
                                     input logic sgn, input logic hi);
    logic [2*WORD_W-1:0] ea;
    logic [2*WORD_W-1:0] eb;
    logic [2*WORD_W-1:0] p;
    ea = sgn ? {{WORD_W{a[WORD_W-1]}}, a} : {{WORD_W{1'b0}}, a};
    eb = sgn ? {{WORD_W{b[WORD_W-1]}}, b} : {{WORD_W{1'b0}}, b};
    p  = ea * eb;
    return word_t'(hi ? p[2*WORD_W-1:WORD_W] : p[WORD_W-1:0]);
  endfunction

  assign clear        = halt || (flush && pc_en);
  assign load         = pc_en && !busy && !clear;
  assign taken_exp    = taken_ref(branch_type, port_a, port_b);
  assign alu_exp      = alu_ref(aluop, port_a, port_b, pc, w_src);
  assign resolved_exp = taken_exp ? pc + imm : pc + 32'd4;
  assign jump_sum     = jump_base + jump_offset;
  assign jump_exp     = {jump_sum[31:1], 1'b0};
  assign mult_exp     = mult_ref(port_a, port_b, mult_signed, mult_high);

  // Length of the current busy run in cycles
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy_len <= 0;
    end else begin
      busy_len <= busy ? busy_len + 1 : 0;
    end
  end

  a_reset: assert property (@(posedge CLK) (!nRST || !$past(nRST))
      |-> !wen_au && !wen_mu && !branch_instr && !jump_instr && !busy)
    else begin
      error_count = error_count + 1;
      $error("MISMATCH %0t: commit outputs or busy not clear around reset", $time);
    end

  a_alu: assert property (@(posedge CLK) disable iff (!nRST)
      load |=> wen_au == $past(dec_wen_au) && wdata_au == $past(alu_exp))
    else begin
      error_count = error_count + 1;
      $error("MISMATCH %0t: ALU write enable or write data", $time);
    end

  a_redirect: assert property (@(posedge CLK) disable iff (!nRST)
      mispredict == (dec_branch_instr & (prediction ^ taken_exp))
      && brj_addr == (dec_jump_instr ? jump_exp : resolved_exp))
    else begin
      error_count = error_count + 1;
      $error("MISMATCH %0t: mispredict or redirect address", $time);
    end

  a_redirect_q: assert property (@(posedge CLK) disable iff (!nRST)
      load |=> branch_instr == $past(dec_branch_instr) && jump_instr == $past(dec_jump_instr)
      && branch_taken_q == $past(taken_exp) && br_resolved_addr == $past(resolved_exp)
      && jump_addr_q == $past(jump_exp))
    else begin
      error_count = error_count + 1;
      $error("MISMATCH %0t: registered branch or jump fields", $time);
    end

  a_commit_fields: assert property (@(posedge CLK) disable iff (!nRST)
      load |=> prediction_q == $past(prediction) && pc_q == $past(pc)
      && reg_rd_q == $past(reg_rd) && wen_mu == $past(dec_wen_mu))
    else begin
      error_count = error_count + 1;
      $error("MISMATCH %0t: registered pc, prediction, destination or wen_mu", $time);
    end

  a_busy_rise: assert property (@(posedge CLK) disable iff (!nRST)
      $rose(mult_start) |-> busy)
    else begin
      error_count = error_count + 1;
      $error("MISMATCH %0t: busy low in the multiply issue cycle", $time);
    end

  a_busy_len: assert property (@(posedge CLK) disable iff (!nRST)
      $fell(busy) && !$past(clear) |-> busy_len == WORD_W + 1)
    else begin
      error_count = error_count + 1;
      $error("MISMATCH %0t: busy lasted %0d cycles", $time, busy_len);
    end

  a_mult: assert property (@(posedge CLK) disable iff (!nRST)
      $fell(busy) && pc_en && !clear && !$past(clear)
      |=> wen_mu && wdata_mu == $past(mult_exp))
    else begin
      error_count = error_count + 1;
      $error("MISMATCH %0t: multiply result %h", $time, wdata_mu);
    end

  a_clear: assert property (@(posedge CLK) disable iff (!nRST)
      clear |=> !wen_au && !wen_mu && !branch_instr && !jump_instr && !busy)
    else begin
      error_count = error_count + 1;
      $error("MISMATCH %0t: outputs not cleared after flush or halt", $time);
    end

endmodule

bind ooo_execute_stage ooo_execute_asserts #(.WORD_W(WORD_W)) asserts_inst (.*);

//--- bench/tb_clock_gen.sv
// Free running testbench clock, 4 ns period
module tb_clock_gen (
  output logic CLK
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

endmodule

//--- bench/tb_ooo_execute_stage.sv
// Testbench top for the execute stage
// Clock and reset, random ALU, branch, jump and multiply traffic,
// flush, halt and stall cycles; the bound assertions check results
module tb_ooo_execute_stage import exec_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WORD_W    = 32;
  localparam int RESET_CYC = 8;
  localparam int MAX_WAIT  = 4 * WORD_W;
  localparam int NUM_INSTR = 300;

  logic              CLK;
  logic              nRST, halt, flush, pc_en;
  logic [WORD_W-1:0] port_a, port_b;
  word_t             pc, imm, jump_base, jump_offset;
  alu_op_t           aluop;
  branch_type_t      branch_type;
  logic              w_src, dec_wen_au, dec_branch_instr, prediction, dec_jump_instr;
  logic              mult_start, mult_signed, mult_high, dec_wen_mu;
  reg_idx_t          reg_rd;
  logic              busy, mispredict, wen_au, wen_mu, branch_instr, branch_taken_q;
  logic              jump_instr, prediction_q;
  word_t             brj_addr, wdata_au, wdata_mu, br_resolved_addr, jump_addr_q, pc_q;
  reg_idx_t          reg_rd_q;

  branch_type_t branch_kinds [6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};

  tb_clock_gen clock_gen_inst (.CLK(CLK));

  ooo_execute_stage #(.WORD_W(WORD_W)) ooo_execute_stage_inst (.*);

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped on failure");
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic clear_issue();
    halt             = 1'b0;
    flush            = 1'b0;
    pc_en            = 1'b1;
    {port_a, port_b} = '0;
    {pc, imm}        = '0;
    jump_base        = '0;
    jump_offset      = '0;
    aluop            = ADD;
    branch_type      = BEQ;
    {w_src, dec_wen_au, dec_branch_instr, prediction, dec_jump_instr} = '0;
    {mult_start, mult_signed, mult_high, dec_wen_mu} = '0;
    reg_rd           = '0;
  endtask

  task automatic fill_operands();
    port_a      = $urandom();
    // Equal operands now and then so the compares see ties
    port_b      = ($urandom_range(3) == 0) ? port_a : $urandom();
    pc          = $urandom() & 32'hFFFF_FFFC;
    imm         = $urandom();
    jump_base   = $urandom();
    jump_offset = $urandom();
    reg_rd      = reg_idx_t'($urandom());
    w_src       = ($urandom_range(7) == 0);
  endtask

  // Hold the multiply until busy drops, or halt it part way
  task automatic run_multiply(input logic cut_short);
    int cycles;
    cycles      = 0;
    mult_start  = 1'b1;
    mult_signed = 1'($urandom_range(1));
    mult_high   = 1'($urandom_range(1));
    dec_wen_mu  = 1'b1;
    next_cycle();
    while (busy && !(cut_short && cycles == 4)) begin
      if (cycles >= MAX_WAIT) begin
        report_failure("Timeout, multiplier busy never dropped");
      end
      next_cycle();
      cycles++;
    end
    if (cut_short) begin
      halt = 1'b1;
      next_cycle();
      clear_issue();
    end
  endtask

  // Halt, flush with pc_en, or flush while stalled
  task automatic cancel_cycle();
    aluop            = alu_op_t'(4'($urandom_range(9)));
    dec_wen_au       = 1'b1;
    dec_branch_instr = 1'($urandom_range(1));
    case ($urandom_range(2))
      0: halt = 1'b1;
      1: flush = 1'b1;
      default: begin
        flush = 1'b1;
        pc_en = 1'b0;
      end
    endcase
    next_cycle();
    clear_issue();
  endtask

  // First assertion error ends the run
  always @(posedge CLK) begin
    if (ooo_execute_stage_inst.asserts_inst.error_count != 0) begin
      report_failure("Assertion error reported by the bound checks");
    end
  end

  initial begin
    void'($urandom(17795));
    clear_issue();
    nRST = 1'b0;
    repeat (RESET_CYC) @(posedge CLK);
    #1;
    nRST = 1'b1;
    next_cycle();
    for (int i = 0; i < NUM_INSTR; i++) begin
      clear_issue();
      fill_operands();
      case ($urandom_range(5))
        0, 1: begin
          aluop      = alu_op_t'(4'($urandom_range(9)));
          dec_wen_au = 1'b1;
        end
        2: begin
          dec_branch_instr = 1'b1;
          branch_type      = branch_kinds[3'($urandom_range(5))];
          prediction       = 1'($urandom_range(1));
        end
        3: begin
          dec_jump_instr = 1'b1;
          dec_wen_au     = 1'b1;
          w_src          = 1'b1;
        end
        4: run_multiply($urandom_range(3) == 0);
        default: cancel_cycle();
      endcase
      next_cycle();
    end
    clear_issue();
    repeat (3) next_cycle();
    if (ooo_execute_stage_inst.asserts_inst.error_count != 0) begin
      report_failure("Assertion errors were reported");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

//--- logic/alu_unit.sv
// Combinational arithmetic unit
// ALU operations plus the pc + 4 link value for jumps
module alu_unit import exec_pkg::*; (
  exec_issue_if.alu issue,
  output word_t     result
);

  word_t      op_a;
  word_t      op_b;
  word_t      alu_out;
  logic [4:0] shamt;

  assign op_a  = word_t'(issue.port_a);
  assign op_b  = word_t'(issue.port_b);
  assign shamt = op_b[4:0];

  always_comb begin
    case (issue.aluop)
      ADD:     alu_out = op_a + op_b;
      SUB:     alu_out = op_a - op_b;
      AND:     alu_out = op_a & op_b;
      OR:      alu_out = op_a | op_b;
      XOR:     alu_out = op_a ^ op_b;
      SLL:     alu_out = op_a << shamt;
      SRL:     alu_out = op_a >> shamt;
      SRA:     alu_out = word_t'($signed(op_a) >>> shamt);
      SLT:     alu_out = word_t'($signed(op_a) < $signed(op_b));
      SLTU:    alu_out = word_t'(op_a < op_b);
      default: alu_out = '0;
    endcase
  end

  // Link address replaces the ALU value for jal/jalr
  assign result = issue.w_src ? issue.pc + word_t'(4) : alu_out;

endmodule

//--- logic/branch_jump_unit.sv
// Branch resolution and jump target calculation
// Taken decision, resolved address, jump target, redirect address
// and mispredict flag, all combinational
module branch_jump_unit import exec_pkg::*; (
  exec_issue_if.branch issue,
  output logic         branch_taken,
  output word_t        resolved_addr,
  output word_t        jump_addr,
  output word_t        brj_addr,
  output logic         mispredict
);

  word_t rs1;
  word_t rs2;
  logic  equal;
  logic  less_signed;
  logic  less_unsigned;

  assign rs1 = word_t'(issue.port_a);
  assign rs2 = word_t'(issue.port_b);

  assign equal         = (rs1 == rs2);
  assign less_signed   = ($signed(rs1) < $signed(rs2));
  assign less_unsigned = (rs1 < rs2);

  always_comb begin
    case (issue.branch_type)
      BEQ:     branch_taken = equal;
      BNE:     branch_taken = !equal;
      BLT:     branch_taken = less_signed;
      BGE:     branch_taken = !less_signed;
      BLTU:    branch_taken = less_unsigned;
      BGEU:    branch_taken = !less_unsigned;
      default: branch_taken = 1'b0;
    endcase
  end

  // Fall through to the next sequential instruction when not taken
  assign resolved_addr = branch_taken ? issue.pc + issue.imm
                                      : issue.pc + word_t'(4);

  // jalr target with bit 0 forced low
  assign jump_addr = (issue.jump_base + issue.jump_offset) & ~word_t'(1);

  assign brj_addr = issue.jump_instr ? jump_addr : resolved_addr;

  assign mispredict = issue.branch_instr & (issue.prediction ^ branch_taken);

endmodule

//--- logic/commit_latch.sv
// Execute to commit pipeline register
// Clears on flush with pc_en or on halt, loads on pc_en when
// the multiplier is not busy, holds otherwise
module commit_latch import exec_pkg::*; (
  input  logic         CLK,
  input  logic         nRST,
  exec_issue_if.commit issue,
  input  logic         halt,
  input  logic         flush,
  input  logic         pc_en,
  input  logic         busy,
  input  word_t        alu_result,
  input  word_t        product,
  input  word_t        resolved_addr,
  input  word_t        jump_addr,
  input  logic         branch_taken,
  output logic         wen_au,
  output logic         wen_mu,
  output logic         branch_instr,
  output logic         branch_taken_q,
  output logic         jump_instr,
  output logic         prediction_q,
  output word_t        wdata_au,
  output word_t        wdata_mu,
  output word_t        br_resolved_addr,
  output word_t        jump_addr_q,
  output word_t        pc_q,
  output reg_idx_t     reg_rd_q
);

  logic clear;
  logic load;

  assign clear = (flush && pc_en) || halt;
  assign load  = pc_en && !busy;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wen_au           <= 1'b0;
      wen_mu           <= 1'b0;
      branch_instr     <= 1'b0;
      branch_taken_q   <= 1'b0;
      jump_instr       <= 1'b0;
      prediction_q     <= 1'b0;
      wdata_au         <= '0;
      wdata_mu         <= '0;
      br_resolved_addr <= '0;
      jump_addr_q      <= '0;
      pc_q             <= '0;
      reg_rd_q         <= '0;
    end else if (clear) begin
      wen_au           <= 1'b0;
      wen_mu           <= 1'b0;
      branch_instr     <= 1'b0;
      branch_taken_q   <= 1'b0;
      jump_instr       <= 1'b0;
      prediction_q     <= 1'b0;
      wdata_au         <= '0;
      wdata_mu         <= '0;
      br_resolved_addr <= '0;
      jump_addr_q      <= '0;
      pc_q             <= '0;
      reg_rd_q         <= '0;
    end else if (load) begin
      // Multiply write enable only gets here once the product is ready
      wen_au           <= issue.wen_au;
      wen_mu           <= issue.wen_mu;
      branch_instr     <= issue.branch_instr;
      branch_taken_q   <= branch_taken;
      jump_instr       <= issue.jump_instr;
      prediction_q     <= issue.prediction;
      wdata_au         <= alu_result;
      wdata_mu         <= product;
      br_resolved_addr <= resolved_addr;
      jump_addr_q      <= jump_addr;
      pc_q             <= issue.pc;
      reg_rd_q         <= issue.reg_rd;
    end
  end

endmodule

//--- logic/exec_issue_if.sv
// Issue bundle from decode to the execute units
// Operands, pc and immediate, per-unit controls and destination register
interface exec_issue_if import exec_pkg::*; #(
  parameter int WORD_W = XLEN
);

  // Register operands follow the datapath width
  logic [WORD_W-1:0] port_a;
  logic [WORD_W-1:0] port_b;
  word_t             pc;
  word_t             imm;

  alu_op_t           aluop;
  logic              w_src;
  logic              wen_au;

  logic              branch_instr;
  branch_type_t      branch_type;
  logic              prediction;
  logic              jump_instr;
  word_t             jump_base;
  word_t             jump_offset;

  logic              mult_start;
  logic              mult_signed;
  logic              mult_high;
  logic              wen_mu;

  reg_idx_t          reg_rd;

  modport alu (input port_a, port_b, pc, imm, aluop, w_src, wen_au);
  modport branch (input port_a, port_b, pc, imm, branch_instr, branch_type,
                  prediction, jump_instr, jump_base, jump_offset);
  modport mult (input port_a, port_b, mult_start, mult_signed, mult_high, wen_mu);
  modport commit (input pc, reg_rd, wen_au, wen_mu, branch_instr, jump_instr,
                  prediction);

endinterface

//--- logic/exec_pkg.sv
// Shared definitions for the execute stage
// Word and register index types, ALU and branch encodings,
// multiplier FSM states
package exec_pkg;

  // Width of addresses, results and the commit datapath
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9
  } alu_op_t;

  // Same values as the funct3 field of the branch opcodes
  typedef enum logic [2:0] {
    BEQ  = 3'd0,
    BNE  = 3'd1,
    BLT  = 3'd4,
    BGE  = 3'd5,
    BLTU = 3'd6,
    BGEU = 3'd7
  } branch_type_t;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    DONE = 2'd2
  } mult_state_t;

endpackage

//--- logic/multiply_unit.sv
// Iterative shift-add multiplier
// IDLE/RUN/DONE FSM, one partial product per cycle, busy flag,
// sign correction and high/low half select
module multiply_unit import exec_pkg::*; #(
  parameter int WORD_W = XLEN
) (
  input  logic       CLK,
  input  logic       nRST,
  exec_issue_if.mult issue,
  input  logic       abort,
  output logic       busy,
  output word_t      product
);

  localparam int CNT_W = $clog2(WORD_W);

  mult_state_t         state;
  logic [CNT_W-1:0]    step;
  logic [WORD_W-1:0]   mcand;
  logic [2*WORD_W-1:0] acc;
  logic                negate;
  logic                high_sel;
  logic                a_neg;
  logic                b_neg;
  logic [WORD_W-1:0]   a_mag;
  logic [WORD_W-1:0]   b_mag;
  logic [WORD_W:0]     partial;
  logic [2*WORD_W-1:0] full;
  logic                start;

  assign start = (state == IDLE) && issue.mult_start;
  assign busy  = start || (state == RUN);

  // Signs only count for a signed multiply
  assign a_neg = issue.mult_signed & issue.port_a[WORD_W-1];
  assign b_neg = issue.mult_signed & issue.port_b[WORD_W-1];
  assign a_mag = a_neg ? -issue.port_a : issue.port_a;
  assign b_mag = b_neg ? -issue.port_b : issue.port_b;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      step  <= '0;
    end else if (abort) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (issue.mult_start) begin
            state <= RUN;
            step  <= '0;
          end
        end
        RUN: begin
          step <= step + CNT_W'(1);
          if (step == CNT_W'(WORD_W - 1)) begin
            state <= DONE;
          end
        end
        DONE:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Upper half accumulates while multiplier bits shift out of the lower half
  assign partial = {1'b0, acc[2*WORD_W-1:WORD_W]}
                 + (acc[0] ? {1'b0, mcand} : {(WORD_W+1){1'b0}});

  always_ff @(posedge CLK) begin
    if (start) begin
      mcand    <= a_mag;
      acc      <= {{WORD_W{1'b0}}, b_mag};
      negate   <= a_neg ^ b_neg;
      high_sel <= issue.mult_high;
    end else if (state == RUN) begin
      acc <= {partial, acc[WORD_W-1:1]};
    end
  end

  assign full = negate ? -acc : acc;

  assign product = (state == DONE)
                 ? word_t'(high_sel ? full[2*WORD_W-1:WORD_W] : full[WORD_W-1:0])
                 : '0;

endmodule

//--- logic/ooo_execute_stage.sv
// Execute stage top level
// Drives the issue bundle from plain ports and connects the ALU,
// branch/jump unit, multiplier and execute/commit register
module ooo_execute_stage import exec_pkg::*; #(
  parameter int WORD_W = XLEN
) (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              halt,
  input  logic              flush,
  input  logic              pc_en,
  // Issue fields from decode
  input  logic [WORD_W-1:0] port_a,
  input  logic [WORD_W-1:0] port_b,
  input  word_t             pc,
  input  word_t             imm,
  input  alu_op_t           aluop,
  input  logic              w_src,
  input  logic              dec_wen_au,
  input  logic              dec_branch_instr,
  input  branch_type_t      branch_type,
  input  logic              prediction,
  input  logic              dec_jump_instr,
  input  word_t             jump_base,
  input  word_t             jump_offset,
  input  logic              mult_start,
  input  logic              mult_signed,
  input  logic              mult_high,
  input  logic              dec_wen_mu,
  input  reg_idx_t          reg_rd,
  // Stall and redirect back to the front end
  output logic              busy,
  output logic              mispredict,
  output word_t             brj_addr,
  // Commit side
  output logic              wen_au,
  output logic              wen_mu,
  output logic              branch_instr,
  output logic              branch_taken_q,
  output logic              jump_instr,
  output logic              prediction_q,
  output word_t             wdata_au,
  output word_t             wdata_mu,
  output word_t             br_resolved_addr,
  output word_t             jump_addr_q,
  output word_t             pc_q,
  output reg_idx_t          reg_rd_q
);

  word_t alu_result;
  word_t product;
  word_t resolved_addr;
  word_t jump_addr;
  logic  branch_taken;
  logic  abort;

  exec_issue_if #(.WORD_W(WORD_W)) issue_if ();

  assign issue_if.port_a       = port_a;
  assign issue_if.port_b       = port_b;
  assign issue_if.pc           = pc;
  assign issue_if.imm          = imm;
  assign issue_if.aluop        = aluop;
  assign issue_if.w_src        = w_src;
  assign issue_if.wen_au       = dec_wen_au;
  assign issue_if.branch_instr = dec_branch_instr;
  assign issue_if.branch_type  = branch_type;
  assign issue_if.prediction   = prediction;
  assign issue_if.jump_instr   = dec_jump_instr;
  assign issue_if.jump_base    = jump_base;
  assign issue_if.jump_offset  = jump_offset;
  assign issue_if.mult_start   = mult_start;
  assign issue_if.mult_signed  = mult_signed;
  assign issue_if.mult_high    = mult_high;
  assign issue_if.wen_mu       = dec_wen_mu;
  assign issue_if.reg_rd       = reg_rd;

  // Same condition that clears the commit register
  assign abort = (flush && pc_en) || halt;

  alu_unit alu_unit_inst (
    .issue  (issue_if.alu),
    .result (alu_result)
  );

  branch_jump_unit branch_jump_unit_inst (
    .issue         (issue_if.branch),
    .branch_taken  (branch_taken),
    .resolved_addr (resolved_addr),
    .jump_addr     (jump_addr),
    .brj_addr      (brj_addr),
    .mispredict    (mispredict)
  );

  multiply_unit #(.WORD_W(WORD_W)) multiply_unit_inst (
    .CLK     (CLK),
    .nRST    (nRST),
    .issue   (issue_if.mult),
    .abort   (abort),
    .busy    (busy),
    .product (product)
  );

  commit_latch commit_latch_inst (
    .CLK              (CLK),
    .nRST             (nRST),
    .issue            (issue_if.commit),
    .halt             (halt),
    .flush            (flush),
    .pc_en            (pc_en),
    .busy             (busy),
    .alu_result       (alu_result),
    .product          (product),
    .resolved_addr    (resolved_addr),
    .jump_addr        (jump_addr),
    .branch_taken     (branch_taken),
    .wen_au           (wen_au),
    .wen_mu           (wen_mu),
    .branch_instr     (branch_instr),
    .branch_taken_q   (branch_taken_q),
    .jump_instr       (jump_instr),
    .prediction_q     (prediction_q),
    .wdata_au         (wdata_au),
    .wdata_mu         (wdata_mu),
    .br_resolved_addr (br_resolved_addr),
    .jump_addr_q      (jump_addr_q),
    .pc_q             (pc_q),
    .reg_rd_q         (reg_rd_q)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_ooo_execute_stage -f sim.f

# Error limit above one lets the testbench report the first assertion error itself
./obj_dir/Vtb_ooo_execute_stage +verilator+error+limit+100 | tee /dev/stderr \
  | grep -q "Simulation finished: PASS"

//--- sim.f
logic/exec_pkg.sv
logic/exec_issue_if.sv
logic/alu_unit.sv
logic/branch_jump_unit.sv
logic/multiply_unit.sv
logic/commit_latch.sv
logic/ooo_execute_stage.sv
bench/tb_clock_gen.sv
bench/ooo_execute_asserts.sv
bench/tb_ooo_execute_stage.sv
